//--- include/blob_track_cfg.svh
`ifndef BLOB_TRACK_CFG_SVH
`define BLOB_TRACK_CFG_SVH

// pixel coordinate widths, sized for a 720p timing grid
`define BT_HCOUNT_W 11
`define BT_VCOUNT_W 10

`define BT_PIX_W 16 // rgb 5-6-5 word
`define BT_CHAN_W 8 // widened channel and threshold bounds

// channel select codes
`define BT_SEL_W 2
`define BT_SEL_GREEN 2'd0
`define BT_SEL_RED 2'd1
`define BT_SEL_BLUE 2'd2
// code 3 is not valid and never yields a hit

`endif

//--- src/blob_track_pkg.sv
`default_nettype none
`include "blob_track_cfg.svh"

package blob_track_pkg;

  // one camera pixel with its position
  typedef struct packed {
    logic valid;
    logic new_frame; // first beat of a frame
    logic [`BT_HCOUNT_W-1:0] hcount;
    logic [`BT_VCOUNT_W-1:0] vcount;
    logic [`BT_PIX_W-1:0] rgb565;
  } pixel_beat_t;

  // threshold setup, held for a frame
  typedef struct packed {
    logic [`BT_SEL_W-1:0] sel;
    logic [`BT_CHAN_W-1:0] lower; // inclusive
    logic [`BT_CHAN_W-1:0] upper; // inclusive
  } thresh_cfg_t;

  // classified pixel out of the classifier
  typedef struct packed {
    logic valid;
    logic new_frame;
    logic hit; // channel within bounds
    logic [`BT_HCOUNT_W-1:0] hcount;
    logic [`BT_VCOUNT_W-1:0] vcount;
  } mask_beat_t;

  // bounding box summary of one finished frame
  typedef struct packed {
    logic found; // at least one hit seen
    logic [`BT_HCOUNT_W-1:0] x_min;
    logic [`BT_HCOUNT_W-1:0] x_max;
    logic [`BT_VCOUNT_W-1:0] y_min;
    logic [`BT_VCOUNT_W-1:0] y_max;
    logic [`BT_HCOUNT_W-1:0] x_center;
    logic [`BT_VCOUNT_W-1:0] y_center;
  } box_t;

endpackage

`default_nettype wire

//--- src/pixel_classifier.sv
`timescale 1ns/1ps
`default_nettype none
`include "blob_track_cfg.svh"

module pixel_classifier import blob_track_pkg::*; (
  input wire clk_pixel,
  input wire sys_rst,
  input wire pixel_beat_t pix,
  input wire thresh_cfg_t cfg,
  output mask_beat_t mask
);

  // 5-6-5 fields padded with zeros up to 8 bits
  logic [`BT_CHAN_W-1:0] red8;
  logic [`BT_CHAN_W-1:0] green8;
  logic [`BT_CHAN_W-1:0] blue8;
  logic [`BT_CHAN_W-1:0] chan_sel; // channel picked by cfg.sel
  logic sel_ok; // select code is a real channel

  // stage 1 registers
  logic s1_valid;
  logic s1_new_frame;
  logic [`BT_HCOUNT_W-1:0] s1_hcount;
  logic [`BT_VCOUNT_W-1:0] s1_vcount;
  logic [`BT_CHAN_W-1:0] s1_chan;
  logic s1_sel_ok;
  logic [`BT_CHAN_W-1:0] s1_lower; // bounds taken with the beat
  logic [`BT_CHAN_W-1:0] s1_upper;

  assign red8 = {pix.rgb565[15:11], 3'b000};
  assign green8 = {pix.rgb565[10:5], 2'b00};
  assign blue8 = {pix.rgb565[4:0], 3'b000};

  always_comb begin
    chan_sel = '0;
    sel_ok = 1'b1;
    case (cfg.sel)
      `BT_SEL_GREEN: chan_sel = green8;
      `BT_SEL_RED: chan_sel = red8;
      `BT_SEL_BLUE: chan_sel = blue8;
      default: sel_ok = 1'b0; // code 3 masks everything off
    endcase
  end

  // stage 1 registers the selected channel plus beat info
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= pix.valid;
    end
    s1_new_frame <= pix.new_frame;
    s1_hcount <= pix.hcount;
    s1_vcount <= pix.vcount;
    s1_chan <= chan_sel;
    s1_sel_ok <= sel_ok;
    s1_lower <= cfg.lower;
    s1_upper <= cfg.upper;
  end

  // stage 2 does the inclusive window compare
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      mask.valid <= 1'b0;
      mask.hit <= 1'b0;
    end else begin
      mask.valid <= s1_valid;
      mask.hit <= s1_valid && s1_sel_ok && (s1_chan >= s1_lower) && (s1_chan <= s1_upper);
    end
    mask.new_frame <= s1_new_frame;
    mask.hcount <= s1_hcount; // coords ride along with the mask
    mask.vcount <= s1_vcount;
  end

  // a hit only ever comes from a valid input beat with a real channel selected
  a_hit_needs_valid: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    mask.hit |-> (mask.valid && $past(pix.valid && (cfg.sel != 2'd3), 2)));

endmodule

`default_nettype wire

//--- src/blob_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "blob_track_cfg.svh"

module blob_tracker import blob_track_pkg::*; (
  input wire clk_pixel,
  input wire sys_rst,
  input wire mask_beat_t mask,
  output box_t box,
  output logic box_valid
);

  logic nf_beat; // valid beat opening a frame
  logic hit_beat; // valid beat inside the window
  logic acc_found; // any hit so far this frame
  logic first_nf; // still waiting on the first frame start

  // running extremes of the current frame
  logic [`BT_HCOUNT_W-1:0] acc_x_min;
  logic [`BT_HCOUNT_W-1:0] acc_x_max;
  logic [`BT_VCOUNT_W-1:0] acc_y_min;
  logic [`BT_VCOUNT_W-1:0] acc_y_max;

  // one extra bit so the sum cannot wrap
  logic [`BT_HCOUNT_W:0] x_sum;
  logic [`BT_VCOUNT_W:0] y_sum;

  assign nf_beat = mask.valid && mask.new_frame;
  assign hit_beat = mask.valid && mask.hit;
  assign x_sum = {1'b0, acc_x_min} + {1'b0, acc_x_max};
  assign y_sum = {1'b0, acc_y_min} + {1'b0, acc_y_max};

  // control and the published box
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      box <= '0;
      box_valid <= 1'b0;
      acc_found <= 1'b0;
      first_nf <= 1'b1;
    end else begin
      box_valid <= 1'b0; // single cycle pulse
      if (nf_beat) begin
        first_nf <= 1'b0;
        if (!first_nf) begin
          box_valid <= 1'b1;
          if (acc_found) begin
            box <= '{
              found: 1'b1,
              x_min: acc_x_min,
              x_max: acc_x_max,
              y_min: acc_y_min,
              y_max: acc_y_max,
              x_center: x_sum[`BT_HCOUNT_W:1],
              y_center: y_sum[`BT_VCOUNT_W:1]
            };
          end else begin
            box <= '0; // empty frame
          end
        end
        acc_found <= mask.hit; // frame start beat counts in the new frame
      end else if (hit_beat) begin
        acc_found <= 1'b1;
      end
    end
  end

  // extremes; only meaningful while acc_found is set
  always_ff @(posedge clk_pixel) begin
    if (nf_beat || (hit_beat && !acc_found)) begin
      acc_x_min <= mask.hcount; // seed from this beat
      acc_x_max <= mask.hcount;
      acc_y_min <= mask.vcount;
      acc_y_max <= mask.vcount;
    end else if (hit_beat) begin
      if (mask.hcount < acc_x_min) acc_x_min <= mask.hcount;
      if (mask.hcount > acc_x_max) acc_x_max <= mask.hcount;
      if (mask.vcount < acc_y_min) acc_y_min <= mask.vcount;
      if (mask.vcount > acc_y_max) acc_y_max <= mask.vcount;
    end
  end

  // a published box is never inverted
  a_box_ordered: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    (box_valid && box.found) |-> (box.x_min <= box.x_max && box.y_min <= box.y_max));

  // back to back pulses only for back to back frame starts
  a_pulse_width: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    (box_valid ##1 box_valid) |-> ($past(nf_beat, 1) && $past(nf_beat, 2)));

endmodule

`default_nettype wire

//--- src/blob_track_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "blob_track_cfg.svh"

module blob_track_top import blob_track_pkg::*; (
  input wire clk_pixel,
  input wire sys_rst,
  input wire pixel_beat_t pix, // camera pixel stream
  input wire thresh_cfg_t cfg, // held steady per frame
  output box_t box,
  output logic box_valid
);

  mask_beat_t mask; // classifier to tracker, 2 cycles behind pix

  // channel select and threshold
  pixel_classifier u_classifier (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .pix(pix),
    .cfg(cfg),
    .mask(mask)
  );

  // per frame bounding box
  blob_tracker u_tracker (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .mask(mask),
    .box(box),
    .box_valid(box_valid)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 4,
  parameter int RST_CYCLES = 3
) (
  output logic clk_pixel,
  output logic sys_rst
);

  initial clk_pixel = 1'b0;
  always #(PERIOD_NS / 2) clk_pixel = ~clk_pixel;

  // reset held over the first few rising edges, released just after one
  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_pixel);
    #1;
    sys_rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/blob_track_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "blob_track_cfg.svh"

module blob_track_tb import blob_track_pkg::*; ();

  localparam int CLK_PERIOD_NS = 4;
  localparam int DRIVE_DLY = 1; // inputs change 1 ns after the rising edge
  localparam int FRAME_W = 16;
  localparam int FRAME_H = 12;
  localparam int FRAME_PIX = FRAME_W * FRAME_H;
  localparam int H_ORG = 100; // frame sits away from the origin
  localparam int V_ORG = 40;
  localparam int N_FRAMES = 8;
  localparam int MAX_GAP = 3; // idle cycles between beats, at most
  localparam int BOX_LATENCY = 3; // new_frame beat in to box_valid out
  localparam int K_RANDOM = 0;
  localparam int K_SPARSE = 1; // hits only on first and last pixel
  localparam int WATCHDOG_NS = (N_FRAMES * FRAME_PIX + 1) * (MAX_GAP + 2) * CLK_PERIOD_NS + 2000;

  logic clk_pixel;
  logic sys_rst;
  pixel_beat_t pix;
  thresh_cfg_t cfg;
  box_t box;
  logic box_valid;

  logic [`BT_PIX_W-1:0] frame_rgb [FRAME_PIX]; // pixels of the frame being sent
  box_t exp_q[$]; // expected boxes, oldest first
  string name_q[$];
  int nf_cyc_q[$]; // monitor cycle of each frame start still to publish
  int neg_cyc = 0;
  int pulses = 0;
  logic nf_seen = 1'b0;
  string cur_name;
  thresh_cfg_t c;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(3)) u_clk_gen (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst)
  );

  blob_track_top uut (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .pix(pix),
    .cfg(cfg),
    .box(box),
    .box_valid(box_valid)
  );

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_box(input string name, input box_t exp, input box_t act);
    if (exp !== act) begin
      $display("Error %s: expected box %p, actual box %p", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic compare_valid_gap(input string name, input int nf_cyc, input int pulse_cyc);
    if (pulse_cyc - nf_cyc != BOX_LATENCY) begin
      $display("Error %s: expected box_valid %0d cycles after frame start, actual %0d",
               name, BOX_LATENCY, pulse_cyc - nf_cyc);
      stop_on_failure();
    end
  endtask

  // 5-6-5 field scaled back to 8 bits; -1 for a select code with no channel
  function automatic int channel_value(input logic [`BT_PIX_W-1:0] rgb,
                                       input logic [`BT_SEL_W-1:0] sel);
    int word;
    word = int'(rgb);
    case (sel)
      `BT_SEL_GREEN: return ((word >> 5) % 64) * 4;
      `BT_SEL_RED: return (word >> 11) * 8;
      `BT_SEL_BLUE: return (word % 32) * 8;
      default: return -1;
    endcase
  endfunction

  // reference box for frame_rgb under cfg c
  function automatic box_t expected_box(input thresh_cfg_t cf);
    box_t b;
    int v;
    int x;
    int y;
    int x_min;
    int x_max;
    int y_min;
    int y_max;
    logic any;
    b = '0;
    any = 1'b0;
    x_min = 0;
    x_max = 0;
    y_min = 0;
    y_max = 0;
    for (int i = 0; i < FRAME_PIX; i++) begin
      v = channel_value(frame_rgb[i], cf.sel);
      x = H_ORG + i % FRAME_W;
      y = V_ORG + i / FRAME_W;
      if (v >= 0 && v >= int'(cf.lower) && v <= int'(cf.upper)) begin
        if (!any) begin // first hit seeds all four
          x_min = x;
          x_max = x;
          y_min = y;
          y_max = y;
        end
        if (x < x_min) x_min = x;
        if (x > x_max) x_max = x;
        if (y < y_min) y_min = y;
        if (y > y_max) y_max = y;
        any = 1'b1;
      end
    end
    if (any) begin
      b.found = 1'b1;
      b.x_min = `BT_HCOUNT_W'(x_min);
      b.x_max = `BT_HCOUNT_W'(x_max);
      b.y_min = `BT_VCOUNT_W'(y_min);
      b.y_max = `BT_VCOUNT_W'(y_max);
      b.x_center = `BT_HCOUNT_W'((x_min + x_max) / 2);
      b.y_center = `BT_VCOUNT_W'((y_min + y_max) / 2);
    end
    return b;
  endfunction

  // overwrite the selected channel so it widens to exactly v
  function automatic logic [`BT_PIX_W-1:0] put_channel(input logic [`BT_PIX_W-1:0] rgb,
      input logic [`BT_SEL_W-1:0] sel, input logic [`BT_CHAN_W-1:0] v);
    logic [`BT_PIX_W-1:0] r;
    r = rgb;
    case (sel)
      `BT_SEL_GREEN: r[10:5] = v[7:2];
      `BT_SEL_RED: r[15:11] = v[7:3];
      `BT_SEL_BLUE: r[4:0] = v[7:3];
      default: r = rgb; // no channel to set
    endcase
    return r;
  endfunction

  function automatic logic [`BT_CHAN_W-1:0] rand_level(input logic [`BT_SEL_W-1:0] sel);
    int step;
    step = (sel == `BT_SEL_GREEN) ? 4 : 8; // reachable levels only
    return `BT_CHAN_W'(($urandom % (256 / step)) * step);
  endfunction

  function automatic thresh_cfg_t random_cfg(input logic [`BT_SEL_W-1:0] sel);
    thresh_cfg_t r;
    logic [`BT_CHAN_W-1:0] a;
    logic [`BT_CHAN_W-1:0] b;
    a = rand_level(sel);
    b = rand_level(sel);
    r.sel = sel;
    r.lower = (a < b) ? a : b;
    r.upper = (a < b) ? b : a;
    return r;
  endfunction

  task automatic build_frame(input thresh_cfg_t cf, input int kind);
    int step;
    int idx;
    step = (cf.sel == `BT_SEL_GREEN) ? 4 : 8;
    for (int i = 0; i < FRAME_PIX; i++) begin
      frame_rgb[i] = `BT_PIX_W'($urandom);
      if (kind == K_SPARSE) frame_rgb[i] = put_channel(frame_rgb[i], cf.sel, 8'h00);
    end
    if (kind == K_SPARSE) begin
      frame_rgb[0] = put_channel(frame_rgb[0], cf.sel, cf.lower); // hit on the frame start
      frame_rgb[FRAME_PIX-1] = put_channel(frame_rgb[FRAME_PIX-1], cf.sel, cf.upper);
    end else begin
      idx = int'($urandom % FRAME_PIX);
      frame_rgb[idx] = put_channel(frame_rgb[idx], cf.sel, cf.lower); // right on the bound
      idx = int'($urandom % FRAME_PIX);
      frame_rgb[idx] = put_channel(frame_rgb[idx], cf.sel, cf.upper);
      idx = int'($urandom % FRAME_PIX);
      if (int'(cf.lower) >= step)
        frame_rgb[idx] = put_channel(frame_rgb[idx], cf.sel, `BT_CHAN_W'(int'(cf.lower) - step));
      idx = int'($urandom % FRAME_PIX);
      if (int'(cf.upper) + step <= 255)
        frame_rgb[idx] = put_channel(frame_rgb[idx], cf.sel, `BT_CHAN_W'(int'(cf.upper) + step));
    end
  endtask

  task automatic drive_idle();
    @(posedge clk_pixel);
    #(DRIVE_DLY);
    pix.valid = 1'b0;
    pix.new_frame = 1'($urandom); // junk, gated by valid
    pix.hcount = `BT_HCOUNT_W'($urandom);
    pix.vcount = `BT_VCOUNT_W'($urandom);
    pix.rgb565 = `BT_PIX_W'($urandom);
  endtask

  task automatic run_frame(input string name, input thresh_cfg_t cf, input int kind,
                           input int max_gap);
    int gap;
    build_frame(cf, kind);
    for (int i = 0; i < FRAME_PIX; i++) begin
      gap = int'($urandom % (max_gap + 1));
      repeat (gap) drive_idle();
      @(posedge clk_pixel);
      #(DRIVE_DLY);
      cfg = cf;
      pix.valid = 1'b1;
      pix.new_frame = (i == 0);
      pix.hcount = `BT_HCOUNT_W'(H_ORG + i % FRAME_W); // raster order
      pix.vcount = `BT_VCOUNT_W'(V_ORG + i / FRAME_W);
      pix.rgb565 = frame_rgb[i];
    end
    exp_q.push_back(expected_box(cf)); // published at the next frame start
    name_q.push_back(name);
  endtask

  // monitor on the falling edge, away from input and output changes
  always @(negedge clk_pixel) begin
    if (sys_rst) begin
      nf_seen = 1'b0;
    end else begin
      neg_cyc = neg_cyc + 1;
      if (pix.valid && pix.new_frame) begin
        if (nf_seen) nf_cyc_q.push_back(neg_cyc); // the first start closes no frame
        nf_seen = 1'b1;
      end
      if (box_valid) begin
        if (exp_q.size() == 0 || nf_cyc_q.size() == 0) begin
          $display("box_valid pulsed while no finished frame was waiting");
          stop_on_failure();
        end else begin
          pulses = pulses + 1;
          cur_name = name_q.pop_front();
          compare_valid_gap(cur_name, nf_cyc_q.pop_front(), neg_cyc);
          compare_box(cur_name, exp_q.pop_front(), box);
        end
      end else if (pulses == 0) begin
        compare_box("reset_state", '0, box); // nothing published yet
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("The simulation timed out before all boxes were published");
    stop_on_failure();
  end

  initial begin
    pix = '0;
    cfg = '0;
    void'($urandom(32'h9b46));
    @(negedge sys_rst);
    repeat (5) drive_idle();
    run_frame("green_bounds", random_cfg(`BT_SEL_GREEN), K_RANDOM, MAX_GAP);
    run_frame("red_bounds", random_cfg(`BT_SEL_RED), K_RANDOM, MAX_GAP);
    run_frame("blue_bounds", random_cfg(`BT_SEL_BLUE), K_RANDOM, MAX_GAP);
    c = '{sel: `BT_SEL_GREEN, lower: 8'hf0, upper: 8'h10}; // empty window
    run_frame("no_hits", c, K_RANDOM, MAX_GAP);
    c = '{sel: 2'd3, lower: 8'h00, upper: 8'hff};
    run_frame("sel_invalid", c, K_RANDOM, MAX_GAP);
    c = '{sel: `BT_SEL_GREEN, lower: 8'h40, upper: 8'h80};
    run_frame("hit_on_frame_start", c, K_SPARSE, MAX_GAP);
    run_frame("red_back_to_back", random_cfg(`BT_SEL_RED), K_RANDOM, 0);
    run_frame("blue_back_to_back", random_cfg(`BT_SEL_BLUE), K_RANDOM, 0);
    // lone frame start to publish the last frame
    @(posedge clk_pixel);
    #(DRIVE_DLY);
    pix.valid = 1'b1;
    pix.new_frame = 1'b1;
    pix.hcount = `BT_HCOUNT_W'(H_ORG);
    pix.vcount = `BT_VCOUNT_W'(V_ORG);
    drive_idle();
    while (exp_q.size() != 0) @(posedge clk_pixel);
    repeat (BOX_LATENCY + 2) drive_idle(); // room for a stray pulse
    if (exp_q.size() == 0 && nf_cyc_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Frames were left unpublished at the end of the run");
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

//--- blob_track.f
+incdir+include
src/blob_track_pkg.sv
src/pixel_classifier.sv
src/blob_tracker.sv
src/blob_track_top.sv
dv/tb_clock_gen.sv
dv/blob_track_tb.sv

//--- Makefile
# Verilator flow for blob_track

TOP_TB := blob_track_tb
TOP_RTL := blob_track_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Iinclude --top-module $(TOP_RTL) \
	  src/blob_track_pkg.sv src/pixel_classifier.sv \
	  src/blob_tracker.sv src/blob_track_top.sv

sim:
	verilator --binary --timing --assert -f blob_track.f --top-module $(TOP_TB)
	@out=$$(./obj_dir/V$(TOP_TB)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
